//--- Makefile
VERILATOR ?= verilator
TOP       ?= resampler_tb
FLIST     ?= resampler.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- decim_round.sv
// decim_i must stay in 1..RATIO_MAX and constant while data flows; the phase restarts only on reset
`timescale 1ns/1ps

module decim_round
    import rs_types_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       en_i,
    input  logic       fir_valid_i,
    input  acc_frame_t fir_data_i,
    input  ratio_t     decim_i,
    input  logic       round_odd_i,
    output logic       out_valid_o,
    output frame_t     out_data_o
);

    ratio_t phase_q;
    ratio_t decim_last;
    logic   keep;
    logic   out_valid_q;
    frame_t out_data_q;

    // round to nearest, ties to even or odd, then clamp to the sample range
    function automatic sample_t round_sat(input acc_t acc, input logic odd);
        logic signed [DATA_WIDTH:0] whole;
        logic [ROUND_SHIFT-1:0]     frac;
        logic                       tie;
        logic                       up;
        whole = {acc[ACC_WIDTH-1], acc[ACC_WIDTH-1:ROUND_SHIFT]};
        frac  = acc[ROUND_SHIFT-1:0];
        tie   = frac[ROUND_SHIFT-1] && (frac[ROUND_SHIFT-2:0] == '0);
        up    = frac[ROUND_SHIFT-1] && (!tie || (whole[0] ^ odd));
        whole = whole + (DATA_WIDTH+1)'(up);
        if (whole[DATA_WIDTH] != whole[DATA_WIDTH-1]) begin
            round_sat = whole[DATA_WIDTH] ? {1'b1, {(DATA_WIDTH-1){1'b0}}}
                                          : {1'b0, {(DATA_WIDTH-1){1'b1}}};
        end else begin
            round_sat = whole[DATA_WIDTH-1:0];
        end
    endfunction

    assign decim_last = decim_i - 1'b1;
    assign keep       = fir_valid_i && (phase_q == '0);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            phase_q     <= '0;
            out_valid_q <= 1'b0;
        end else if (en_i) begin
            out_valid_q <= keep;
            if (fir_valid_i) begin
                phase_q <= (phase_q >= decim_last) ? '0 : phase_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && keep) begin
            for (int c = 0; c < CH_NUM; c++) begin
                out_data_q[c*DATA_WIDTH +: DATA_WIDTH] <=
                    round_sat(fir_data_i[c*ACC_WIDTH +: ACC_WIDTH], round_odd_i);
            end
        end
    end

    assign out_valid_o = out_valid_q && en_i;   // one pulse per kept item
    assign out_data_o  = out_data_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_decim_nonzero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fir_valid_i |-> (decim_i != '0))
        else $error("decim_i is zero while filter data arrives");

endmodule

//--- fir_coef_pkg.sv
// coefficients are fixed; their sum is slightly above 2^18, so a held -32768 input overflows the 34-bit sum
package fir_coef_pkg;

    localparam int COEF_WIDTH = 18;
    localparam int TAP_NUM    = 8;

    typedef logic signed [COEF_WIDTH-1:0] coef_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // symmetric low-pass set, tap 0 multiplies the newest sample
    // DC gain is sum / 2^18, just over unity so a held +32767 saturates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam coef_t COEF_TABLE [TAP_NUM] = '{
        coef_t'(6000),
        coef_t'(18000),
        coef_t'(42000),
        coef_t'(65075),
        coef_t'(65075),
        coef_t'(42000),
        coef_t'(18000),
        coef_t'(6000)
    };

endpackage

//--- fir_filter.sv
// fixed 2-cycle latency, one output per input strobe; the 34-bit sum wraps if the taps overflow it
`timescale 1ns/1ps

module fir_filter
    import rs_types_pkg::*;
    import fir_coef_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       en_i,
    input  logic       stuff_valid_i,
    input  frame_t     stuff_data_i,
    output logic       fir_valid_o,
    output acc_frame_t fir_data_o
);

    // newest sample comes straight from the input, the rest from the delay line,
    // so TAP_NUM-1 stored samples make a TAP_NUM-deep window
    sample_t    dly_q  [CH_NUM][TAP_NUM-1];
    sample_t    win    [CH_NUM][TAP_NUM];
    acc_t       prod_q [CH_NUM][TAP_NUM];
    acc_t       acc_sum [CH_NUM];
    logic       prod_valid_q;
    logic       sum_valid_q;
    acc_frame_t fir_data_q;

    always_comb begin
        for (int c = 0; c < CH_NUM; c++) begin
            win[c][0] = sample_t'(stuff_data_i[c*DATA_WIDTH +: DATA_WIDTH]);
            for (int k = 1; k < TAP_NUM; k++) begin
                win[c][k] = dly_q[c][k-1];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // delay line and stage 1 products
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < CH_NUM; c++) begin
                for (int k = 0; k < TAP_NUM-1; k++) begin
                    dly_q[c][k] <= '0;
                end
            end
        end else if (en_i && stuff_valid_i) begin
            for (int c = 0; c < CH_NUM; c++) begin
                for (int k = 0; k < TAP_NUM-1; k++) begin
                    dly_q[c][k] <= win[c][k];   // shift by one sample
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && stuff_valid_i) begin
            for (int c = 0; c < CH_NUM; c++) begin
                for (int k = 0; k < TAP_NUM; k++) begin
                    prod_q[c][k] <= win[c][k] * COEF_TABLE[k];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2 sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int c = 0; c < CH_NUM; c++) begin
            acc_sum[c] = '0;
            for (int k = 0; k < TAP_NUM; k++) begin
                acc_sum[c] = acc_sum[c] + prod_q[c][k];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && prod_valid_q) begin
            for (int c = 0; c < CH_NUM; c++) begin
                fir_data_q[c*ACC_WIDTH +: ACC_WIDTH] <= acc_sum[c];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            prod_valid_q <= 1'b0;
            sum_valid_q  <= 1'b0;
        end else if (en_i) begin
            prod_valid_q <= stuff_valid_i;
            sum_valid_q  <= prod_valid_q;
        end
    end

    assign fir_valid_o = sum_valid_q && en_i;
    assign fir_data_o  = fir_data_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [2:0] inflight_q;  // strobes taken in but not yet out

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            inflight_q <= '0;
        end else if (en_i) begin
            inflight_q <= inflight_q + 3'(stuff_valid_i) - 3'(fir_valid_o);
        end
    end

    a_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fir_valid_o |-> (inflight_q != '0))
        else $error("fir_valid_o without an input strobe still in flight");

    a_depth: assert property (@(posedge clk_i) disable iff (!rstn_i)
        inflight_q <= 3'd2)
        else $error("more than two input strobes in flight");

endmodule

//--- resampler.f
fir_coef_pkg.sv
rs_types_pkg.sv
zero_stuffer.sv
fir_filter.sv
decim_round.sv
resampler.sv
resampler_checker.sv
resampler_tb.sv

//--- resampler.sv
// ratios and round mode are sampled live and must not change while data flows; no output back-pressure
`timescale 1ns/1ps

module resampler
    import rs_types_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   en_i,
    input  logic   in_valid_i,
    input  frame_t in_data_i,
    input  ratio_t interp_i,
    input  ratio_t decim_i,
    input  logic   round_odd_i,
    output logic   in_ready_o,
    output logic   out_valid_o,
    output frame_t out_data_o
);

    logic       stuff_valid;
    frame_t     stuff_data;
    logic       fir_valid;
    acc_frame_t fir_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // upsample, filter, decimate
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    zero_stuffer i_zero_stuffer (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .en_i         (en_i),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .interp_i     (interp_i),
        .in_ready_o   (in_ready_o),
        .stuff_valid_o(stuff_valid),
        .stuff_data_o (stuff_data)
    );

    fir_filter i_fir_filter (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .en_i         (en_i),
        .stuff_valid_i(stuff_valid),
        .stuff_data_i (stuff_data),
        .fir_valid_o  (fir_valid),
        .fir_data_o   (fir_data)
    );

    decim_round i_decim_round (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .en_i       (en_i),
        .fir_valid_i(fir_valid),
        .fir_data_i (fir_data),
        .decim_i    (decim_i),
        .round_odd_i(round_odd_i),
        .out_valid_o(out_valid_o),
        .out_data_o (out_data_o)
    );

endmodule

//--- resampler_checker.sv
// order-only compare; expected frames are built at the accepting edge, so output timing is not checked
`timescale 1ns/1ps

module resampler_checker
    import rs_types_pkg::*;
    import fir_coef_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   en_i,
    input  logic   in_valid_i,
    input  logic   in_ready_i,
    input  frame_t in_data_i,
    input  ratio_t interp_i,
    input  ratio_t decim_i,
    input  logic   round_odd_i,
    input  logic   out_valid_i,
    input  frame_t out_data_i,
    input  logic   check_empty_i,
    output int     mism_cnt_o,
    output int     proto_cnt_o,
    output int     pending_o
);

    longint hist [CH_NUM][TAP_NUM];   // model delay line, index 0 newest
    frame_t exp_q [$];
    frame_t exp_f;
    int     phase;
    int     busy;                     // enabled edges with in_ready still low
    logic   after_rst;
    int     mism_cnt  = 0;
    int     proto_cnt = 0;
    int     pending   = 0;

    assign mism_cnt_o  = mism_cnt;
    assign proto_cnt_o = proto_cnt;
    assign pending_o   = pending;

    // nearest integer of acc / 2^ROUND_SHIFT, halves go to the wanted parity
    function automatic sample_t nearest_sample(input longint acc, input logic odd);
        longint q;
        longint rem;
        longint half;
        longint hi;
        half = longint'(1) <<< (ROUND_SHIFT - 1);
        hi   = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
        q    = acc >>> ROUND_SHIFT;   // floor
        rem  = acc - (q <<< ROUND_SHIFT);
        if (rem > half) begin
            q = q + 1;
        end else if (rem == half && (q[0] != odd)) begin
            q = q + 1;
        end
        if (q > hi) q = hi;
        if (q < -hi - 1) q = -hi - 1;
        return sample_t'(q);
    endfunction

    // one zero-stuffed sample through the filter and the decimator
    task automatic push_sample(input frame_t s);
        longint acc;
        for (int c = 0; c < CH_NUM; c++) begin
            for (int k = TAP_NUM - 1; k > 0; k--) begin
                hist[c][k] = hist[c][k-1];
            end
            hist[c][0] = longint'(sample_t'(s[c*DATA_WIDTH +: DATA_WIDTH]));
            acc = 0;
            for (int k = 0; k < TAP_NUM; k++) begin
                acc = acc + hist[c][k] * longint'(COEF_TABLE[k]);
            end
            acc = (acc <<< (64 - ACC_WIDTH)) >>> (64 - ACC_WIDTH);  // 34-bit sum wraps
            exp_f[c*DATA_WIDTH +: DATA_WIDTH] = nearest_sample(acc, round_odd_i);
        end
        if (phase == 0) exp_q.push_back(exp_f);
        phase = (phase + 1 >= int'(decim_i)) ? 0 : phase + 1;
    endtask

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < CH_NUM; c++) begin
                for (int k = 0; k < TAP_NUM; k++) hist[c][k] = 0;
            end
            exp_q.delete();
            phase     = 0;
            busy      = 0;
            after_rst = 1'b1;
        end else begin
            if (after_rst && out_valid_i) begin
                $display("error: out_valid_o high on the first cycle after reset");
                proto_cnt++;
            end
            after_rst = 1'b0;
            if (!en_i && (in_ready_i || out_valid_i)) begin
                $display("error: in_ready_o or out_valid_o high while en_i is low");
                proto_cnt++;
            end
            if (en_i) begin
                if (busy > 0) begin
                    if (in_ready_i) begin
                        $display("error: in_ready_o high while zero frames are still due");
                        proto_cnt++;
                    end
                    busy--;
                end else if (!in_ready_i) begin
                    $display("error: in_ready_o did not return after the zero frames");
                    proto_cnt++;
                end
                if (in_valid_i && in_ready_i) begin
                    for (int s = 0; s < int'(interp_i); s++) begin
                        push_sample(s == 0 ? in_data_i : frame_t'(0));
                    end
                    busy = int'(interp_i) - 1;
                end
                if (out_valid_i) begin
                    if (exp_q.size() == 0) begin
                        $display("error: output frame %h came with no frame expected", out_data_i);
                        proto_cnt++;
                    end else begin
                        exp_f = exp_q.pop_front();
                        if (out_data_i !== exp_f) begin
                            $display("ERR %0t: output frame got %h expected %h",
                                     $time, out_data_i, exp_f);
                            mism_cnt++;
                        end
                    end
                end
            end
        end
        if (check_empty_i && exp_q.size() != 0) begin
            $display("error: %0d expected frames never came out", exp_q.size());
            proto_cnt++;
        end
        pending = exp_q.size();
    end

endmodule

//--- resampler_tb.sv
// each case starts from reset with its ratios set; a failed handshake ends the run, a slow drain does not
`timescale 1ns/1ps

module resampler_tb
    import rs_types_pkg::*;
();

    typedef enum logic [1:0] {
        PAT_IMPULSE,
        PAT_RANDOM,
        PAT_FULL,
        PAT_TIE
    } pattern_e;

    typedef struct packed {
        int       interp;
        int       decim;
        logic     odd;
        int       frames;
        pattern_e kind;
        logic     gaps;     // random en_i drops
    } case_t;

    localparam int N_CASES     = 8;
    localparam int READY_LIMIT = 200;
    localparam int DRAIN_LIMIT = 400;

    logic   clk_i;
    logic   rstn_i;
    logic   en_i;
    logic   in_valid_i;
    frame_t in_data_i;
    ratio_t interp_i;
    ratio_t decim_i;
    logic   round_odd_i;
    logic   in_ready_o;
    logic   out_valid_o;
    frame_t out_data_o;

    case_t       cases [N_CASES];
    logic        check_empty;
    logic        timed_out;
    int          timeouts;
    int          mism_cnt;
    int          proto_cnt;
    int          pending;
    int unsigned seed_ret;

    always #10 clk_i = ~clk_i;

    resampler dut_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .en_i       (en_i),
        .in_valid_i (in_valid_i),
        .in_data_i  (in_data_i),
        .interp_i   (interp_i),
        .decim_i    (decim_i),
        .round_odd_i(round_odd_i),
        .in_ready_o (in_ready_o),
        .out_valid_o(out_valid_o),
        .out_data_o (out_data_o)
    );

    resampler_checker chk_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .en_i         (en_i),
        .in_valid_i   (in_valid_i),
        .in_ready_i   (in_ready_o),
        .in_data_i    (in_data_i),
        .interp_i     (interp_i),
        .decim_i      (decim_i),
        .round_odd_i  (round_odd_i),
        .out_valid_i  (out_valid_o),
        .out_data_i   (out_data_o),
        .check_empty_i(check_empty),
        .mism_cnt_o   (mism_cnt),
        .proto_cnt_o  (proto_cnt),
        .pending_o    (pending)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // case table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fill_case_table();
        cases[0] = '{interp: 1, decim: 1, odd: 1'b0, frames: 12, kind: PAT_IMPULSE, gaps: 1'b0};
        cases[1] = '{interp: 3, decim: 1, odd: 1'b0, frames: 8,  kind: PAT_RANDOM,  gaps: 1'b0};
        cases[2] = '{interp: 2, decim: 4, odd: 1'b0, frames: 24, kind: PAT_RANDOM,  gaps: 1'b0};
        cases[3] = '{interp: 1, decim: 4, odd: 1'b1, frames: 30, kind: PAT_RANDOM,  gaps: 1'b0};
        cases[4] = '{interp: 1, decim: 1, odd: 1'b0, frames: 10, kind: PAT_TIE,     gaps: 1'b0};
        cases[5] = '{interp: 1, decim: 1, odd: 1'b1, frames: 10, kind: PAT_TIE,     gaps: 1'b0};
        cases[6] = '{interp: 1, decim: 1, odd: 1'b0, frames: 14, kind: PAT_FULL,    gaps: 1'b0};
        cases[7] = '{interp: 2, decim: 3, odd: 1'b1, frames: 20, kind: PAT_RANDOM,  gaps: 1'b1};
    endtask

    function automatic frame_t make_frame(input pattern_e kind, input int idx);
        frame_t f;
        f = '0;
        case (kind)
            PAT_IMPULSE: if (idx == 0) f = {sample_t'(-16384), sample_t'(16384)};
            PAT_RANDOM:  f = frame_t'($urandom);
            PAT_FULL:    f = {sample_t'(-32767), sample_t'(32767)};  // held, fills every tap
            // 8192 times each of the three smaller taps lands exactly on a half
            PAT_TIE:     if (idx == 0) f = {sample_t'(-8192), sample_t'(8192)};
            default:     f = '0;
        endcase
        return f;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_frame(input frame_t data, input logic gaps);
        int   waited;
        logic taken;
        waited     = 0;
        taken      = 1'b0;
        in_valid_i = 1'b1;
        in_data_i  = data;
        while (!taken && waited < READY_LIMIT) begin
            @(posedge clk_i);
            taken = in_ready_o;     // already includes en_i
            #2;
            if (gaps) en_i = ($urandom_range(0, 3) != 0);
            waited++;
        end
        in_valid_i = 1'b0;
        if (!taken) begin
            $display("timeout: in_ready_o never came back within %0d cycles", READY_LIMIT);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic drain_pipeline(input logic gaps);
        int n;
        n = 0;
        while (pending != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk_i);
            #2;
            if (gaps) en_i = ($urandom_range(0, 3) != 0);
            n++;
        end
        en_i = 1'b1;
        if (pending != 0) begin
            $display("timeout: %0d expected frames still pending after %0d cycles",
                     pending, DRAIN_LIMIT);
            timeouts++;
        end
        repeat (6) @(posedge clk_i);  // room for any extra output
        #2 check_empty = 1'b1;
        @(posedge clk_i);
        #2 check_empty = 1'b0;
    endtask

    task automatic run_case(input case_t row);
        in_valid_i  = 1'b0;
        en_i        = 1'b1;
        interp_i    = ratio_t'(row.interp);
        decim_i     = ratio_t'(row.decim);
        round_odd_i = row.odd;
        rstn_i      = 1'b0;
        repeat (2) @(posedge clk_i);
        #2 rstn_i = 1'b1;
        for (int f = 0; f < row.frames && !timed_out; f++) begin
            send_frame(make_frame(row.kind, f), row.gaps);
        end
        if (!timed_out) drain_pipeline(row.gaps);
    endtask

    initial begin
        seed_ret    = $urandom(32'h5f12);
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        en_i        = 1'b0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        interp_i    = ratio_t'(1);
        decim_i     = ratio_t'(1);
        round_odd_i = 1'b0;
        check_empty = 1'b0;
        timed_out   = 1'b0;
        timeouts    = 0;
        fill_case_table();
        for (int r = 0; r < N_CASES; r++) begin
            if (!timed_out) run_case(cases[r]);
        end
        $display("summary: %0d value errors, %0d protocol errors, %0d timeouts",
                 mism_cnt, proto_cnt, timeouts);
        if (mism_cnt == 0 && proto_cnt == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- rs_types_pkg.sv
// compile after fir_coef_pkg; all widths are fixed here, ratios outside 1..RATIO_MAX are illegal
package rs_types_pkg;
    import fir_coef_pkg::*;

    localparam int CH_NUM      = 2;
    localparam int DATA_WIDTH  = 16;
    localparam int RATIO_WIDTH = 4;
    localparam int RATIO_MAX   = 8;

    // full-precision filter result and the bits that rounding drops
    localparam int ACC_WIDTH   = DATA_WIDTH + COEF_WIDTH;
    localparam int ROUND_SHIFT = ACC_WIDTH - DATA_WIDTH;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector types, channel 0 sits in the low bits of a frame
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic signed [DATA_WIDTH-1:0]     sample_t;
    typedef logic        [CH_NUM*DATA_WIDTH-1:0] frame_t;
    typedef logic signed [ACC_WIDTH-1:0]      acc_t;
    typedef logic        [CH_NUM*ACC_WIDTH-1:0]  acc_frame_t;
    typedef logic        [RATIO_WIDTH-1:0]    ratio_t;

endpackage

//--- zero_stuffer.sv
// interp_i must stay in 1..RATIO_MAX and constant while frames flow; in_data_i held while waiting
`timescale 1ns/1ps

module zero_stuffer
    import rs_types_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   en_i,
    input  logic   in_valid_i,
    input  frame_t in_data_i,
    input  ratio_t interp_i,
    output logic   in_ready_o,
    output logic   stuff_valid_o,
    output frame_t stuff_data_o
);

    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_STUFF = 1'b1
    } state_e;

    state_e state_q;
    ratio_t zero_cnt_q;     // zeros already sent for the current frame
    ratio_t zero_cnt_nxt;
    ratio_t interp_last;
    logic   stuff_valid_q;
    frame_t stuff_data_q;
    logic   accept;

    assign in_ready_o   = rstn_i && en_i && (state_q == ST_IDLE);
    assign accept       = in_valid_i && in_ready_o;
    assign zero_cnt_nxt = zero_cnt_q + 1'b1;
    assign interp_last  = interp_i - 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q       <= ST_IDLE;
            zero_cnt_q    <= '0;
            stuff_valid_q <= 1'b0;
        end else if (en_i) begin
            unique case (state_q)
                ST_IDLE: begin
                    stuff_valid_q <= accept;
                    zero_cnt_q    <= '0;
                    if (accept && (interp_i > ratio_t'(1))) begin
                        state_q <= ST_STUFF;
                    end
                end
                ST_STUFF: begin
                    stuff_valid_q <= 1'b1;  // one zero frame per enabled cycle
                    zero_cnt_q    <= zero_cnt_nxt;
                    if (zero_cnt_nxt >= interp_last) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (accept) begin
                stuff_data_q <= in_data_i;
            end else if (state_q == ST_STUFF) begin
                stuff_data_q <= '0;
            end
        end
    end

    // a held strobe shows only on enabled cycles
    assign stuff_valid_o = stuff_valid_q && en_i;
    assign stuff_data_o  = stuff_data_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_interp_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        in_valid_i |-> (interp_i >= ratio_t'(1)) && (interp_i <= ratio_t'(RATIO_MAX)))
        else $error("interp_i out of range: %0d", interp_i);

    a_ready_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept && (interp_i > ratio_t'(1)) |=> !in_ready_o)
        else $error("in_ready_o high right after a frame that needs zero frames");

endmodule
